/* source/fetch_pkg.sv */
package fetch_pkg;

    // Datapath widths
    localparam int xlen        = 32;
    localparam int line_bits   = 128;
    localparam int line_instrs = 4;                   // Instructions per fetch line
    localparam int line_bytes  = 16;
    localparam int instr_bytes = xlen / 8;

    // PC bits below a line boundary
    localparam int line_off_bits = $clog2(line_bytes);

    // Branch target buffer geometry
    localparam int btb_entries  = 16;
    localparam int btb_idx_bits = $clog2(btb_entries);               // PC[7:4]
    localparam int btb_tag_bits = xlen - btb_idx_bits - line_off_bits;

    // Instruction buffer sizing
    localparam int buf_depth    = 8;                  // Two full lines
    localparam int buf_ptr_bits = $clog2(buf_depth);
    localparam int buf_cnt_bits = $clog2(buf_depth + 1);

    // Reset vector
    localparam logic [xlen-1:0] reset_pc = '0;

    // 2-bit saturating branch counter
    typedef enum logic [1:0] {
        strong_nt = 2'd0,
        weak_nt   = 2'd1,
        weak_t    = 2'd2,
        strong_t  = 2'd3
    } ctr_state_t;

    // Clear the offset bits so the address points at a line
    function automatic logic [xlen-1:0] line_align(input logic [xlen-1:0] addr);
        return {addr[xlen-1:line_off_bits], {line_off_bits{1'b0}}};
    endfunction

endpackage

/* source/fetch_pc.sv */
`timescale 1ns/1ps

module fetch_pc import fetch_pkg::*; (
    input  logic            clk,
    input  logic            rst,

    // Resteer from the reorder buffer, highest priority
    input  logic            rob_resteer,
    input  logic [xlen-1:0] rob_target,

    // Resteer from decode
    input  logic            dec_resteer,
    input  logic [xlen-1:0] dec_target,

    // Branch target buffer lookup result
    input  logic            pred_taken,
    input  logic [xlen-1:0] pred_target,

    input  logic            line_ready,     // Buffer has room for a whole line

    output logic [xlen-1:0] fetch_pc,
    output logic            fetch_req,
    output logic            flush
);

    logic [xlen-1:0] next_pc;
    logic [xlen-1:0] seq_pc;

    assign seq_pc    = fetch_pc + xlen'(line_bytes);
    assign fetch_req = line_ready;
    assign flush     = rob_resteer | dec_resteer;   // Any resteer drops buffered work

    // Fixed priority: ROB, decode, stall, prediction, sequential
    always_comb begin
        if (rob_resteer) begin
            next_pc = rob_target;
        end else if (dec_resteer) begin
            next_pc = dec_target;
        end else if (!fetch_req) begin
            next_pc = fetch_pc;                     // Stall
        end else if (pred_taken) begin
            next_pc = pred_target;
        end else begin
            next_pc = seq_pc;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            fetch_pc <= reset_pc;
        end else begin
            // Targets may come in unaligned
            fetch_pc <= line_align(next_pc);
        end
    end

endmodule

/* source/branch_predictor.sv */
`timescale 1ns/1ps

module branch_predictor import fetch_pkg::*; (
    input  logic            clk,
    input  logic            rst,

    // Lookup port, combinational
    input  logic [xlen-1:0] lookup_pc,

    // Training from branch resolution
    input  logic            update_valid,
    input  logic [xlen-1:0] update_pc,
    input  logic [xlen-1:0] update_target,
    input  logic            update_taken,

    output logic            pred_taken,
    output logic [xlen-1:0] pred_target
);

    logic [btb_entries-1:0]  entry_valid;
    logic [btb_tag_bits-1:0] entry_tag    [btb_entries];
    logic [xlen-1:0]         entry_target [btb_entries];
    ctr_state_t              entry_ctr    [btb_entries];

    logic [btb_idx_bits-1:0] lookup_idx;
    logic [btb_tag_bits-1:0] lookup_tag;
    logic [btb_idx_bits-1:0] upd_idx;
    logic [btb_tag_bits-1:0] upd_tag;
    logic                    upd_hit;
    logic                    lookup_hit;

    // One step toward the outcome, saturating at both ends
    function automatic ctr_state_t ctr_step(input ctr_state_t c, input logic taken);
        unique case (c)
            strong_nt: return taken ? weak_nt  : strong_nt;
            weak_nt:   return taken ? weak_t   : strong_nt;
            weak_t:    return taken ? strong_t : weak_nt;
            strong_t:  return taken ? strong_t : weak_t;
            default:   return weak_nt;
        endcase
    endfunction

    assign lookup_idx = lookup_pc[line_off_bits +: btb_idx_bits];
    assign lookup_tag = lookup_pc[xlen-1 -: btb_tag_bits];
    assign upd_idx    = update_pc[line_off_bits +: btb_idx_bits];
    assign upd_tag    = update_pc[xlen-1 -: btb_tag_bits];

    assign lookup_hit = entry_valid[lookup_idx] && (entry_tag[lookup_idx] == lookup_tag);
    assign upd_hit    = entry_valid[upd_idx] && (entry_tag[upd_idx] == upd_tag);

    // Taken on a hit with the counter in one of the upper two states
    always_comb begin
        pred_taken  = lookup_hit &&
                      (entry_ctr[lookup_idx] == weak_t || entry_ctr[lookup_idx] == strong_t);
        pred_target = entry_target[lookup_idx];
    end

    // Valid bits
    always_ff @(posedge clk) begin
        if (rst) begin
            entry_valid <= '0;
        end else if (update_valid && !upd_hit && update_taken) begin
            entry_valid[upd_idx] <= 1'b1;           // Allocate on taken miss
        end
    end

    // Tag, target and counter storage
    always_ff @(posedge clk) begin
        if (update_valid) begin
            if (upd_hit) begin
                entry_ctr[upd_idx] <= ctr_step(entry_ctr[upd_idx], update_taken);
                if (update_taken) begin
                    entry_target[upd_idx] <= update_target;
                end
            end else if (update_taken) begin
                // New entry starts weakly taken
                entry_tag[upd_idx]    <= upd_tag;
                entry_target[upd_idx] <= update_target;
                entry_ctr[upd_idx]    <= weak_t;
            end
            // Not-taken miss leaves the table alone
        end
    end

endmodule

/* source/instr_buffer.sv */
`timescale 1ns/1ps

module instr_buffer import fetch_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,
    input  logic                 flush,

    // Line write side
    input  logic                 load,
    input  logic [xlen-1:0]      load_pc,
    input  logic [line_bits-1:0] line_data,

    // Decode side
    input  logic                 instr_take,

    output logic                 line_ready,
    output logic [xlen-1:0]      instr,
    output logic [xlen-1:0]      instr_pc,
    output logic                 instr_valid
);

    logic [xlen-1:0] instr_mem [buf_depth];
    logic [xlen-1:0] pc_mem    [buf_depth];

    logic [buf_ptr_bits-1:0] wr_ptr;
    logic [buf_ptr_bits-1:0] rd_ptr;
    logic [buf_cnt_bits-1:0] count;

    logic do_load;
    logic do_pop;

    // Room for one more whole line
    assign line_ready  = count <= buf_cnt_bits'(buf_depth - line_instrs);
    assign instr_valid = count != '0;

    assign do_load = load && !flush;                // Line in a resteer cycle is dropped
    assign do_pop  = instr_take && instr_valid;

    // Oldest entry goes out
    assign instr    = instr_mem[rd_ptr];
    assign instr_pc = pc_mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_load) begin
                wr_ptr <= wr_ptr + buf_ptr_bits'(line_instrs);
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Load and pop can land on the same edge
            case ({do_load, do_pop})
                2'b10:   count <= count + buf_cnt_bits'(line_instrs);
                2'b01:   count <= count - 1'b1;
                2'b11:   count <= count + buf_cnt_bits'(line_instrs - 1);
                default: count <= count;
            endcase
        end
    end

    // Payload write, four slots per line, pointer wraps on its own
    always_ff @(posedge clk) begin
        if (do_load) begin
            for (int k = 0; k < line_instrs; k++) begin
                instr_mem[wr_ptr + buf_ptr_bits'(k)] <= line_data[xlen*k +: xlen];
                pc_mem[wr_ptr + buf_ptr_bits'(k)]    <= load_pc + xlen'(instr_bytes * k);
            end
        end
    end

endmodule

/* source/fetch_top.sv */
`timescale 1ns/1ps

module fetch_top import fetch_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,

    // Instruction memory, line returned in the same cycle
    input  logic [line_bits-1:0] line_data,

    // Branch resolution
    input  logic                 update_valid,
    input  logic [xlen-1:0]      update_pc,
    input  logic [xlen-1:0]      update_target,
    input  logic                 update_taken,

    // Resteers
    input  logic                 rob_resteer,
    input  logic [xlen-1:0]      rob_target,
    input  logic                 dec_resteer,
    input  logic [xlen-1:0]      dec_target,

    input  logic                 instr_take,

    output logic [xlen-1:0]      fetch_pc,
    output logic                 fetch_req,
    output logic [xlen-1:0]      instr,
    output logic [xlen-1:0]      instr_pc,
    output logic                 instr_valid
);

    logic            pred_taken;
    logic [xlen-1:0] pred_target;
    logic            line_ready;
    logic            flush;

    fetch_pc pc_unit (
        .clk         (clk),
        .rst         (rst),
        .rob_resteer (rob_resteer),
        .rob_target  (rob_target),
        .dec_resteer (dec_resteer),
        .dec_target  (dec_target),
        .pred_taken  (pred_taken),
        .pred_target (pred_target),
        .line_ready  (line_ready),   // Advance only when the buffer can take a line
        .fetch_pc    (fetch_pc),
        .fetch_req   (fetch_req),
        .flush       (flush)
    );

    branch_predictor btb (
        .clk           (clk),
        .rst           (rst),
        .lookup_pc     (fetch_pc),
        .update_valid  (update_valid),
        .update_pc     (update_pc),
        .update_target (update_target),
        .update_taken  (update_taken),
        .pred_taken    (pred_taken),
        .pred_target   (pred_target)
    );

    instr_buffer ibuf (
        .clk         (clk),
        .rst         (rst),
        .flush       (flush),
        .load        (fetch_req),
        .load_pc     (fetch_pc),
        .line_data   (line_data),
        .instr_take  (instr_take),
        .line_ready  (line_ready),
        .instr       (instr),
        .instr_pc    (instr_pc),
        .instr_valid (instr_valid)
    );

endmodule

/* bench/fetch_tb.sv */
`timescale 1ns/1ps

module fetch_tb import fetch_pkg::*; ();

    localparam int clk_period = 40;
    // Reset 2, sequential 60, random take 400, resteers 40, training 30, decay 30
    localparam int stim_cycles = 562;

    logic                 clk;
    logic                 rst;
    logic [line_bits-1:0] line_data;
    logic                 update_valid;
    logic [xlen-1:0]      update_pc;
    logic [xlen-1:0]      update_target;
    logic                 update_taken;
    logic                 rob_resteer;
    logic [xlen-1:0]      rob_target;
    logic                 dec_resteer;
    logic [xlen-1:0]      dec_target;
    logic                 instr_take;
    logic [xlen-1:0]      fetch_pc;
    logic                 fetch_req;
    logic [xlen-1:0]      instr;
    logic [xlen-1:0]      instr_pc;
    logic                 instr_valid;

    // Mirror of the branch target buffer
    logic            m_valid  [btb_entries];
    logic [23:0]     m_tag    [btb_entries];
    logic [xlen-1:0] m_target [btb_entries];
    int              m_ctr    [btb_entries];

    logic [xlen-1:0] exp_q [$];         // Expected instruction addresses
    logic [xlen-1:0] exp_line;
    logic [xlen-1:0] hold_pc;
    logic            hold_pending;
    int              n_checked;
    integer          seed;
    string           phase_name;

    fetch_top uut (
        .clk           (clk),
        .rst           (rst),
        .line_data     (line_data),
        .update_valid  (update_valid),
        .update_pc     (update_pc),
        .update_target (update_target),
        .update_taken  (update_taken),
        .rob_resteer   (rob_resteer),
        .rob_target    (rob_target),
        .dec_resteer   (dec_resteer),
        .dec_target    (dec_target),
        .instr_take    (instr_take),
        .fetch_pc      (fetch_pc),
        .fetch_req     (fetch_req),
        .instr         (instr),
        .instr_pc      (instr_pc),
        .instr_valid   (instr_valid)
    );

    // Memory contents depend on every address bit
    function automatic logic [xlen-1:0] mem_word(input logic [xlen-1:0] addr);
        return addr ^ 32'h5a3c_96e1;
    endfunction

    // Combinational memory returns the line at the current fetch address
    assign line_data = {mem_word(fetch_pc + 32'd12), mem_word(fetch_pc + 32'd8),
                        mem_word(fetch_pc + 32'd4), mem_word(fetch_pc)};

    // Line that follows a fetched line by prediction or in sequence
    function automatic logic [xlen-1:0] next_line(input logic [xlen-1:0] line);
        int idx;
        idx = line[7:4];
        if (m_valid[idx] && m_tag[idx] == line[31:8] && m_ctr[idx] >= 2) begin
            return {m_target[idx][31:4], 4'h0};
        end
        return line + 32'd16;
    endfunction

    function automatic void model_update(input logic [xlen-1:0] pc,
                                         input logic [xlen-1:0] target,
                                         input logic taken);
        int idx;
        idx = pc[7:4];
        if (m_valid[idx] && m_tag[idx] == pc[31:8]) begin
            if (taken) begin
                m_ctr[idx]    = (m_ctr[idx] == 3) ? 3 : m_ctr[idx] + 1;
                m_target[idx] = target;
            end else begin
                m_ctr[idx] = (m_ctr[idx] == 0) ? 0 : m_ctr[idx] - 1;
            end
        end else if (taken) begin
            m_valid[idx]  = 1'b1;
            m_tag[idx]    = pc[31:8];
            m_target[idx] = target;
            m_ctr[idx]    = int'(weak_t);
        end
    endfunction

    task automatic check_value(input string test_name, input logic [xlen-1:0] expected,
                               input logic [xlen-1:0] actual);
        if (expected !== actual) begin
            $display("[ERROR] %s: expected %h, actual %h", test_name, expected, actual);
            $display("TEST FAILED");
            $fatal(1, "value mismatch in %s", test_name);
        end
    endtask

    task automatic clear_strobes();
        update_valid = 1'b0;
        rob_resteer  = 1'b0;
        dec_resteer  = 1'b0;
    endtask

    // Returns on a falling edge once n more instructions were checked
    task automatic wait_checked(input int n);
        int target;
        target = n_checked + n;
        while (n_checked < target) begin
            @(negedge clk);
        end
    endtask

    // Random decode stalls until n more instructions were checked
    task automatic take_randomly(input int n);
        int target;
        target = n_checked + n;
        while (n_checked < target) begin
            @(negedge clk);
            instr_take = (($random(seed) & 3) == 0);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // Compare process sees the pre-edge values of everything
    always @(posedge clk) begin
        if (rst) begin
            exp_q.delete();
            exp_line     = 32'd0;
            hold_pending = 1'b0;
            n_checked    = 0;
            for (int i = 0; i < btb_entries; i++) begin
                m_valid[i] = 1'b0;
                m_ctr[i]   = 0;
            end
        end else begin
            if (hold_pending) begin
                check_value("stall_hold", hold_pc, fetch_pc);
            end
            hold_pending = !fetch_req && !rob_resteer && !dec_resteer;
            hold_pc      = fetch_pc;
            if (update_valid) begin
                model_update(update_pc, update_target, update_taken);
            end
            if (rob_resteer || dec_resteer) begin
                exp_q.delete();             // ROB target wins over decode
                exp_line = rob_resteer ? {rob_target[31:4], 4'h0} : {dec_target[31:4], 4'h0};
            end else if (instr_valid && instr_take) begin
                if (exp_q.size() == 0) begin
                    for (int k = 0; k < line_instrs; k++) begin
                        exp_q.push_back(exp_line + 32'(4 * k));
                    end
                    exp_line = next_line(exp_line);
                end
                check_value(phase_name, exp_q[0], instr_pc);
                check_value({phase_name, "_data"}, mem_word(exp_q[0]), instr);
                void'(exp_q.pop_front());
                n_checked++;
            end
        end
    end

    initial begin
        #((stim_cycles + 50) * clk_period);
        $display("Timeout: the DUT stopped delivering instructions");
        $display("TEST FAILED");
        $fatal(1, "watchdog expired");
    end

    initial begin
        seed          = 32'h6b7e_2dfd;
        phase_name    = "reset";
        rst           = 1'b1;
        update_pc     = '0;
        update_target = '0;
        update_taken  = 1'b0;
        rob_target    = '0;
        dec_target    = '0;
        instr_take    = 1'b0;
        clear_strobes();
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        check_value("reset_valid", 32'd0, {31'd0, instr_valid});
        check_value("reset_pc", 32'd0, fetch_pc);
        check_value("reset_req", 32'd1, {31'd0, fetch_req});

        phase_name = "sequential";
        instr_take = 1'b1;
        wait_checked(40);

        // Decode stalls often so the buffer fills up
        phase_name = "backpressure";
        take_randomly(40);

        phase_name  = "resteer_both";
        instr_take  = 1'b0;
        rob_resteer = 1'b1;
        rob_target  = 32'h0000_1000;
        dec_resteer = 1'b1;
        dec_target  = 32'h0000_2000;
        @(negedge clk);
        clear_strobes();
        instr_take = 1'b1;
        wait_checked(10);

        phase_name  = "resteer_dec";
        instr_take  = 1'b0;
        dec_resteer = 1'b1;
        dec_target  = 32'h0000_3000;
        @(negedge clk);
        clear_strobes();
        instr_take = 1'b1;
        wait_checked(10);

        // Taken branch in line 0x4020 with a restart just ahead of it
        phase_name    = "btb_train";
        instr_take    = 1'b0;
        update_valid  = 1'b1;
        update_pc     = 32'h0000_4020;
        update_target = 32'h0000_5000;
        update_taken  = 1'b1;
        rob_resteer   = 1'b1;
        rob_target    = 32'h0000_4000;
        @(negedge clk);
        clear_strobes();
        instr_take = 1'b1;
        wait_checked(24);

        phase_name   = "btb_decay";
        instr_take   = 1'b0;
        update_valid = 1'b1;
        update_taken = 1'b0;
        @(negedge clk);
        rob_resteer = 1'b1;                 // Second not-taken update with the restart
        @(negedge clk);
        clear_strobes();
        instr_take = 1'b1;
        wait_checked(24);

        $display("TEST PASSED");
        $finish;
    end

endmodule

/* project.f */
source/fetch_pkg.sv
source/fetch_pc.sv
source/branch_predictor.sv
source/instr_buffer.sv
source/fetch_top.sv
bench/fetch_tb.sv

/* Bender.yml */
package:
  name: fetch_frontend

sources:
  - source/fetch_pkg.sv
  - source/fetch_pc.sv
  - source/branch_predictor.sv
  - source/instr_buffer.sv
  - source/fetch_top.sv
  - target: simulation
    files:
      - bench/fetch_tb.sv
